/* verilog.f */
+incdir+verilog
verilog/cache_pkg.sv
verilog/bus_pkg.sv
verilog/cache_ram.sv
verilog/line_transfer.sv
verilog/cache_ctrl.sv
verilog/d_cache.sv
tests/mem_model.sv
tests/d_cache_tb.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it, and decide from the log
verilator --binary --timing --assert -Wno-fatal --top-module d_cache_tb \
	-f verilog.f -o d_cache_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/d_cache_sim > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || grep -q "SIMULATION PASSED" sim.log || exit 1

/* tests/d_cache_tb.sv */
// testbench top for d_cache, runs directed and random loads and stores against a byte shadow
`include "cache_settings.svh"

module d_cache_tb;

	localparam int PERIOD = 4;
	localparam int RESET_CYCLES = 10;
	localparam int RAND_OPS = 300;
	// directed ops plus the random run
	localparam int NUM_OPS = RAND_OPS + 10;
	localparam logic [31:0] SEED = 32'hfd3d54b1;
	localparam logic [31:0] FILL_KEY = 32'h5a3c96e1;
	// four aliasing tags over all 256 lines
	localparam int REGION_BYTES = 65536;

	logic                clk = 1'b0;
	logic                reset;
	cache_pkg::cpu_req_t cpu_req;
	logic                cpu_mem_en;
	cache_pkg::cpu_rsp_t cpu_rsp;
	bus_pkg::bus_req_t   bus_req;
	bus_pkg::bus_rsp_t   bus_rsp;

	integer seed = SEED;
	// byte image of the region as the cpu should see it
	logic [7:0]  shadow [REGION_BYTES];
	// expected responses in issue order with bit 32 marking a store
	logic [32:0] exp_q [$];
	logic [32:0] exp_head;
	int errors = 0;
	int checks = 0;
	int test_num = 0;
	int test_errors = 0;
	// bus beats seen so far in total and in write-back bursts
	int beats = 0;
	int wr_beats = 0;
	// bus address of the latest read and write burst
	logic [31:0] rd_addr = '0;
	logic [31:0] wr_addr = '0;

	always #(PERIOD / 2) clk = ~clk;

	d_cache UUT (
		.clk(clk), .reset(reset), .cpu_req(cpu_req), .cpu_mem_en(cpu_mem_en),
		.cpu_rsp(cpu_rsp), .bus_req(bus_req), .bus_rsp(bus_rsp)
	);

	mem_model #(.WORDS(REGION_BYTES / 4), .FILL_KEY(FILL_KEY), .SEED(SEED)) u_mem (
		.clk(clk), .bus_req(bus_req), .bus_rsp(bus_rsp)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s expected %h got %h", name, expected, actual);
		end
	endtask

	// region byte address with tag 15:14, index 13:6 and word 5:2
	function automatic logic [31:0] make_addr(input int tag, input int index, input int offset);
		return {16'h0, 2'(tag), 8'(index), 4'(offset), 2'b00};
	endfunction

	// initial memory byte is the word address xor the key taken little endian
	function automatic logic [7:0] fill_byte(input int i);
		return 8'((32'(i / 4) ^ FILL_KEY) >> (8 * (i % 4)));
	endfunction

	// word the cpu must read after all earlier stores
	function automatic logic [31:0] ref_word(input logic [31:0] addr);
		return {shadow[{addr[15:2], 2'd3}], shadow[{addr[15:2], 2'd2}],
			shadow[{addr[15:2], 2'd1}], shadow[{addr[15:2], 2'd0}]};
	endfunction

	task automatic shadow_write(input logic [31:0] addr, input logic [3:0] be,
			input logic [31:0] data);
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				shadow[{addr[15:2], 2'(b)}] = data[8*b +: 8];
			end
		end
	endtask

	// one request entered and left on a rising edge
	// lat counts edges from acceptance to data_ok
	task automatic run_op(input logic [31:0] addr, input logic we, input logic [3:0] be,
			input logic [31:0] wdata, output int lat);
		cache_pkg::cpu_req_t r;
		r.addr = cache_pkg::addr_fields_t'(addr);
		r.we = we;
		r.be = be;
		r.wdata = wdata;
		while (!cpu_rsp.addr_ok) begin
			@(posedge clk);
		end
		if (we) begin
			exp_q.push_back({1'b1, 32'h0});
		end else begin
			exp_q.push_back({1'b0, ref_word(addr)});
		end
		cpu_req <= r;
		cpu_mem_en <= 1'b1;
		// accept edge
		@(posedge clk);
		cpu_mem_en <= 1'b0;
		lat = 0;
		do begin
			@(posedge clk);
			lat++;
		end while (!cpu_rsp.data_ok);
		if (we) begin
			shadow_write(addr, be, wdata);
		end
	endtask

	// lets the compare process catch up, then reports the test
	task automatic finish_test(input string name);
		@(negedge clk);
		if (exp_q.size() != 0) begin
			errors++;
			$display("responses missing for %0d requests", exp_q.size());
			exp_q.delete();
		end
		test_num++;
		if (errors == test_errors) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			$display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
		end
		test_errors = errors;
		@(posedge clk);
	endtask

	// read data is checked against the value queued at issue
	always @(posedge clk) begin
		if (!reset && cpu_rsp.data_ok) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("data_ok came with no request outstanding");
			end else begin
				exp_head = exp_q.pop_front();
				if (!exp_head[32]) begin
					check_value("cpu_rsp.rdata", exp_head[31:0], cpu_rsp.rdata);
				end
			end
		end
	end

	// bus monitor for line alignment, beat counts and burst addresses
	always @(posedge clk) begin
		if (!reset && bus_req.as) begin
			check_value("bus_req.addr[5:0]", 32'd0, 32'(bus_req.addr[5:0]));
			if (bus_rsp.ready) begin
				beats++;
				if (bus_req.rw == bus_pkg::BUS_WRITE) begin
					wr_beats++;
					wr_addr = bus_req.addr;
				end else begin
					rd_addr = bus_req.addr;
				end
			end
		end
	end

	// bound by the worst miss with stalls
	initial begin
		#((NUM_OPS * 80 + RESET_CYCLES) * PERIOD);
		$display("watchdog timeout, the cache stopped answering requests");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int lat;
		int base_beats;
		int base_wr;
		logic [31:0] addr;
		logic [31:0] rnd;
		logic [31:0] wdata;
		reset = 1'b1;
		cpu_mem_en = 1'b0;
		cpu_req = '0;
		for (int i = 0; i < REGION_BYTES; i++) begin
			shadow[i] = fill_byte(i);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		check_value("cpu_rsp.addr_ok", 32'd1, 32'(cpu_rsp.addr_ok));
		check_value("cpu_rsp.data_ok", 32'd0, 32'(cpu_rsp.data_ok));
		check_value("bus_req.as", 32'd0, 32'(bus_req.as));
		finish_test("reset state");

		// index 5 is clean so only a refill runs
		base_beats = beats;
		base_wr = wr_beats;
		run_op(make_addr(0, 5, 3), 1'b0, 4'h0, 32'h0, lat);
		check_value("refill ready count", 32'd16, 32'(beats - base_beats));
		check_value("write-back ready count", 32'd0, 32'(wr_beats - base_wr));
		check_value("refill bus_req.addr", make_addr(0, 5, 0), rd_addr);
		finish_test("read miss refill");

		base_beats = beats;
		run_op(make_addr(0, 5, 7), 1'b0, 4'h0, 32'h0, lat);
		check_value("read hit latency", 32'd3, 32'(lat));
		check_value("ready count on hit", 32'd0, 32'(beats - base_beats));
		finish_test("read hit");

		// partial stores merge into the resident word
		run_op(make_addr(0, 5, 7), 1'b1, 4'b0101, 32'haabbccdd, lat);
		check_value("write hit latency", 32'd3, 32'(lat));
		run_op(make_addr(0, 5, 7), 1'b1, 4'b1000, 32'h11223344, lat);
		run_op(make_addr(0, 5, 7), 1'b0, 4'h0, 32'h0, lat);
		run_op(make_addr(0, 5, 0), 1'b1, 4'b1111, 32'hcafef00d, lat);
		run_op(make_addr(0, 5, 0), 1'b0, 4'h0, 32'h0, lat);
		finish_test("byte-enable writes");

		// tag 2 evicts the dirty tag 0 line
		base_beats = beats;
		base_wr = wr_beats;
		run_op(make_addr(2, 5, 7), 1'b0, 4'h0, 32'h0, lat);
		check_value("write-back ready count", 32'd16, 32'(wr_beats - base_wr));
		check_value("total ready count", 32'd32, 32'(beats - base_beats));
		check_value("write-back bus_req.addr", make_addr(0, 5, 0), wr_addr);
		check_value("refill bus_req.addr", make_addr(2, 5, 0), rd_addr);
		for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
			addr = make_addr(0, 5, k);
			check_value("mem_model line word", ref_word(addr), u_mem.mem[addr[15:2]]);
		end
		// evicted line comes back from memory
		run_op(make_addr(0, 5, 7), 1'b0, 4'h0, 32'h0, lat);
		finish_test("dirty eviction");

		// 8 indices and 4 tags give frequent conflicts
		for (int i = 0; i < RAND_OPS; i++) begin
			rnd = $random(seed);
			wdata = $random(seed);
			addr = make_addr(int'(rnd[1:0]), int'(rnd[4:2]), int'(rnd[8:5]));
			run_op(addr, rnd[9], rnd[13:10], wdata, lat);
		end
		finish_test("random traffic");

		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* tests/mem_model.sv */
// behavioral main memory for the cache testbench, answers line bursts with random ready stalls
`include "cache_settings.svh"

module mem_model #(
	parameter int WORDS = 16384,
	parameter logic [31:0] FILL_KEY = 32'h0,
	parameter logic [31:0] SEED = 32'h1
) (
	input  logic              clk,
	input  bus_pkg::bus_req_t bus_req,
	output bus_pkg::bus_rsp_t bus_rsp
);

	localparam int AW = $clog2(WORDS);

	// contents stay readable from the testbench
	cache_pkg::word_t mem [WORDS];
	// word number inside the current burst
	logic [`CACHE_OFFSET_W-1:0] cnt = '0;
	// ready decision for this cycle, redrawn every clock
	logic go = 1'b0;
	integer seed = SEED;
	logic [AW-1:0] waddr;

	// fill is the word address xor a key
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = 32'(i) ^ FILL_KEY;
		end
	end

	// line-aligned bus address plus burst count
	assign waddr = {bus_req.addr[AW+1:2+`CACHE_OFFSET_W], cnt};

	// never ready without as
	always_comb begin
		bus_rsp.ready = bus_req.as && go;
		bus_rsp.rdata = mem[waddr];
	end

	always @(posedge clk) begin
		// roughly one cycle in four stalls
		go <= ($random(seed) & 3) != 0;
		if (!bus_req.as) begin
			cnt <= '0;
		end else if (go) begin
			cnt <= cnt + 1'b1;
			// store the word the cache drives this beat
			if (bus_req.rw == bus_pkg::BUS_WRITE) begin
				mem[waddr] = bus_req.wdata;
			end
		end
	end

endmodule

/* verilog/d_cache.sv */
// direct-mapped write-back data cache top, connecting cpu port, memory bus, FSM and RAMs
`include "cache_settings.svh"

module d_cache (
	input  logic                clk,
	input  logic                reset,
	input  cache_pkg::cpu_req_t cpu_req,
	input  logic                cpu_mem_en,
	output cache_pkg::cpu_rsp_t cpu_rsp,
	output bus_pkg::bus_req_t   bus_req,
	input  bus_pkg::bus_rsp_t   bus_rsp
);

	localparam int LINES = 1 << `CACHE_INDEX_W;
	localparam int WORDS = LINES * `CACHE_LINE_WORDS;
	localparam int RAM_AW = `CACHE_INDEX_W + `CACHE_OFFSET_W;

	cache_pkg::cpu_req_t     req_q;
	logic                    accept;
	logic                    addr_ok;
	logic                    data_ok;
	cache_pkg::tag_entry_t   tag_rdata;
	logic                    tag_we;
	logic [RAM_AW-1:0]       ctrl_addr;
	logic [RAM_AW-1:0]       xfer_addr;
	logic [RAM_AW-1:0]       ram_addr;
	logic                    ctrl_we;
	logic                    xfer_we;
	logic                    ram_we;
	cache_pkg::word_t        ctrl_wdata;
	cache_pkg::word_t        xfer_wdata;
	cache_pkg::word_t        ram_wdata;
	cache_pkg::word_t        ram_rdata;
	logic                    xfer_start;
	logic                    xfer_busy;
	logic                    xfer_done;
	bus_pkg::bus_dir_t       xfer_dir;
	cache_pkg::addr_fields_t xfer_line_addr;

	// one request in flight, taken only while idle
	assign accept = cpu_mem_en && addr_ok;

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= cpu_req;
		end
	end

	always_comb begin
		cpu_rsp.addr_ok = addr_ok;
		cpu_rsp.data_ok = data_ok;
		cpu_rsp.rdata   = ram_rdata;
	end

	// burst engine owns the data ram while a line moves
	assign ram_addr = xfer_busy ? xfer_addr : ctrl_addr;
	assign ram_we = xfer_busy ? xfer_we : ctrl_we;
	assign ram_wdata = xfer_busy ? xfer_wdata : ctrl_wdata;

	cache_ctrl u_ctrl (
		.clk(clk), .reset(reset), .start(accept), .req(req_q),
		.tag_rdata(tag_rdata), .tag_we(tag_we),
		.data_addr(ctrl_addr), .data_rdata(ram_rdata), .data_we(ctrl_we),
		.data_wdata(ctrl_wdata), .xfer_start(xfer_start), .xfer_dir(xfer_dir),
		.xfer_line_addr(xfer_line_addr), .xfer_done(xfer_done),
		.addr_ok(addr_ok), .data_ok(data_ok)
	);

	line_transfer u_xfer (
		.clk(clk), .reset(reset), .start(xfer_start), .dir(xfer_dir),
		.line_addr(xfer_line_addr), .index(req_q.addr.index),
		.bus_req(bus_req), .bus_rsp(bus_rsp),
		.ram_addr(xfer_addr), .ram_we(xfer_we), .ram_wdata(xfer_wdata),
		.ram_rdata(ram_rdata), .busy(xfer_busy), .done(xfer_done)
	);

	// tag row follows the registered request index
	cache_ram #(.entry_t(cache_pkg::tag_entry_t), .DEPTH(LINES)) tag_ram (
		.clk(clk), .addr(req_q.addr.index), .we(tag_we),
		.wdata(req_q.addr.tag), .rdata(tag_rdata)
	);

	cache_ram #(.entry_t(cache_pkg::word_t), .DEPTH(WORDS)) data_ram (
		.clk(clk), .addr(ram_addr), .we(ram_we),
		.wdata(ram_wdata), .rdata(ram_rdata)
	);

	// the FSM never starts a second burst over a running one
	assert property (@(posedge clk) disable iff (reset) xfer_start |-> !xfer_busy);

endmodule

/* verilog/cache_ctrl.sv */
// cache FSM with valid and dirty bits, hit check and store merge, instantiated by d_cache
`include "cache_settings.svh"

module cache_ctrl (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      start,
	input  cache_pkg::cpu_req_t                       req,
	input  cache_pkg::tag_entry_t                     tag_rdata,
	output logic                                      tag_we,
	output logic [`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] data_addr,
	input  cache_pkg::word_t                          data_rdata,
	output logic                                      data_we,
	output cache_pkg::word_t                          data_wdata,
	output logic                                      xfer_start,
	output bus_pkg::bus_dir_t                         xfer_dir,
	output cache_pkg::addr_fields_t                   xfer_line_addr,
	input  logic                                      xfer_done,
	output logic                                      addr_ok,
	output logic                                      data_ok
);

	localparam int LINES = 1 << `CACHE_INDEX_W;
	localparam int BYTE_W = `CACHE_WORD_W / `CACHE_BYTES;

	cache_pkg::ctrl_state_t state;
	// high in the second lookup cycle when both ram outputs are valid
	logic                   compare;
	logic [LINES-1:0]       valid;
	logic [LINES-1:0]       dirty;
	logic                   hit;
	logic                   in_lookup;
	cache_pkg::word_t       merged;

	assign in_lookup = (state == cache_pkg::CTRL_LOOKUP);
	assign hit = valid[req.addr.index] && (tag_rdata == req.addr.tag);

	// old word with the enabled store bytes replaced
	always_comb begin
		merged = data_rdata;
		for (int b = 0; b < `CACHE_BYTES; b++) begin
			if (req.be[b]) begin
				merged[b*BYTE_W +: BYTE_W] = req.wdata[b*BYTE_W +: BYTE_W];
			end
		end
	end

	assign addr_ok = (state == cache_pkg::CTRL_IDLE);
	// request word stays addressed through idle so rdata holds with data_ok
	assign data_addr = {req.addr.index, req.addr.offset};
	assign data_wdata = merged;
	assign data_we = in_lookup && compare && hit && req.we;
	// refill finishing installs the new tag
	assign tag_we = (state == cache_pkg::CTRL_REFILL) && xfer_done;

	// miss starts a burst, refill follows a finished write-back
	assign xfer_start = (in_lookup && compare && !hit)
		|| ((state == cache_pkg::CTRL_WB) && xfer_done);
	assign xfer_dir = (in_lookup && dirty[req.addr.index]) ? bus_pkg::BUS_WRITE
		: bus_pkg::BUS_READ;

	// victim line on write-back, requested line on refill
	always_comb begin
		xfer_line_addr = '0;
		xfer_line_addr.index = req.addr.index;
		if (xfer_dir == bus_pkg::BUS_WRITE) begin
			xfer_line_addr.tag = tag_rdata;
		end else begin
			xfer_line_addr.tag = req.addr.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= cache_pkg::CTRL_IDLE;
			compare <= 1'b0;
			data_ok <= 1'b0;
		end else begin
			// lookup always leaves after its compare cycle
			compare <= in_lookup && !compare;
			data_ok <= in_lookup && compare && hit;
			case (state)
				cache_pkg::CTRL_IDLE: begin
					if (start) begin
						state <= cache_pkg::CTRL_LOOKUP;
					end
				end
				cache_pkg::CTRL_LOOKUP: begin
					if (compare) begin
						if (hit) begin
							state <= cache_pkg::CTRL_IDLE;
						end else if (dirty[req.addr.index]) begin
							state <= cache_pkg::CTRL_WB;
						end else begin
							state <= cache_pkg::CTRL_REFILL;
						end
					end
				end
				cache_pkg::CTRL_WB: begin
					if (xfer_done) begin
						state <= cache_pkg::CTRL_REFILL;
					end
				end
				default: begin
					// look the request up again once the line is in
					if (xfer_done) begin
						state <= cache_pkg::CTRL_LOOKUP;
					end
				end
			endcase
		end
	end

	// fresh line is clean, a store hit marks it dirty
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
		end else if (tag_we) begin
			valid[req.addr.index] <= 1'b1;
			dirty[req.addr.index] <= 1'b0;
		end else if (data_we) begin
			dirty[req.addr.index] <= 1'b1;
		end
	end

	// a response needs the ram read cycle and the compare cycle of lookup
	assert property (@(posedge clk) disable iff (reset)
		data_ok |-> $past(state) == cache_pkg::CTRL_LOOKUP
			&& $past(state, 2) == cache_pkg::CTRL_LOOKUP);

endmodule

/* verilog/line_transfer.sv */
// burst engine that moves one cache line between data RAM and memory bus, started by cache_ctrl
`include "cache_settings.svh"

module line_transfer (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      start,
	input  bus_pkg::bus_dir_t                         dir,
	input  cache_pkg::addr_fields_t                   line_addr,
	input  logic [`CACHE_INDEX_W-1:0]                 index,
	output bus_pkg::bus_req_t                         bus_req,
	input  bus_pkg::bus_rsp_t                         bus_rsp,
	output logic [`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] ram_addr,
	output logic                                      ram_we,
	output cache_pkg::word_t                          ram_wdata,
	input  cache_pkg::word_t                          ram_rdata,
	output logic                                      busy,
	output logic                                      done
);

	// one extra bit so the count can reach the full line
	localparam int CNT_W = $clog2(`CACHE_LINE_WORDS) + 1;
	localparam logic [CNT_W-1:0] LINE_END = CNT_W'(`CACHE_LINE_WORDS);

	logic [CNT_W-1:0]            cnt;
	logic [CNT_W-1:0]            cnt_next;
	logic [`CACHE_OFFSET_W-1:0]  word_sel;
	// first busy cycle only fetches word 0, as waits for it
	logic                        primed;
	logic                        beat;
	bus_pkg::bus_dir_t           dir_q;
	cache_pkg::addr_fields_t     addr_q;
	logic [`CACHE_INDEX_W-1:0]   index_q;

	// a word moves when memory answers an active burst
	assign beat = bus_req.as && bus_rsp.ready;
	assign cnt_next = cnt + {{(CNT_W-1){1'b0}}, beat};

	always_ff @(posedge clk) begin
		if (reset) begin
			busy   <= 1'b0;
			primed <= 1'b0;
			done   <= 1'b0;
			cnt    <= '0;
		end else begin
			done <= busy && (cnt_next == LINE_END);
			if (start) begin
				busy   <= 1'b1;
				primed <= 1'b0;
				cnt    <= '0;
			end else if (busy) begin
				primed <= 1'b1;
				cnt    <= cnt_next;
				// as drops right after the last ready
				if (cnt_next == LINE_END) begin
					busy   <= 1'b0;
					primed <= 1'b0;
				end
			end
		end
	end

	// burst parameters held for the whole transfer
	always_ff @(posedge clk) begin
		if (start) begin
			dir_q           <= dir;
			index_q         <= index;
			addr_q          <= line_addr;
			addr_q.offset   <= '0;
			addr_q.byte_off <= '0;
		end
	end

	always_comb begin
		bus_req.as    = busy && primed;
		bus_req.rw    = dir_q;
		bus_req.addr  = addr_q;
		// ram output already holds the current word on write-back
		bus_req.wdata = ram_rdata;
	end

	// write-back reads one word ahead, refill writes the word on the bus
	assign word_sel = (dir_q == bus_pkg::BUS_WRITE) ? cnt_next[`CACHE_OFFSET_W-1:0]
		: cnt[`CACHE_OFFSET_W-1:0];
	assign ram_addr = {index_q, word_sel};
	assign ram_we = beat && (dir_q == bus_pkg::BUS_READ);
	assign ram_wdata = bus_rsp.rdata;

	assert property (@(posedge clk) disable iff (reset) cnt <= LINE_END);

endmodule

/* verilog/cache_ram.sv */
// synchronous single-port RAM with a typed entry, instantiated for both tag and data arrays
module cache_ram #(
	parameter type entry_t = cache_pkg::word_t,
	parameter int DEPTH = 256
) (
	input  logic                     clk,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic                     we,
	input  entry_t                   wdata,
	output entry_t                   rdata
);

	entry_t mem [DEPTH];

	// read-first, so a write cycle returns the old entry
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

	// writes need a known address inside the array
	assert property (@(posedge clk) we |-> !$isunknown(addr) && (int'(addr) < DEPTH));

endmodule

/* verilog/bus_pkg.sv */
// memory bus types for line bursts and the read or write direction, shared by RTL and memory model
`include "cache_settings.svh"

package bus_pkg;

	// rw encoding on the bus
	typedef enum logic {
		BUS_READ  = 1'b0,
		BUS_WRITE = 1'b1
	} bus_dir_t;

	// as stays high for the whole burst
	typedef struct packed {
		logic                     as;
		bus_dir_t                 rw;
		logic [`CACHE_ADDR_W-1:0] addr;
		cache_pkg::word_t         wdata;
	} bus_req_t;

	// one word moves on every cycle with ready high
	typedef struct packed {
		logic             ready;
		cache_pkg::word_t rdata;
	} bus_rsp_t;

endpackage

/* verilog/cache_pkg.sv */
// cache-side types for the address split, stored tags, cpu request and response, and FSM states
`include "cache_settings.svh"

package cache_pkg;

	// byte select bits below the word offset
	localparam int BYTE_OFF_W = $clog2(`CACHE_BYTES);

	typedef logic [`CACHE_WORD_W-1:0] word_t;

	// one tag array entry
	typedef logic [`CACHE_TAG_W-1:0] tag_entry_t;

	// byte address seen as its cache fields
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0]    tag;
		logic [`CACHE_INDEX_W-1:0]  index;
		logic [`CACHE_OFFSET_W-1:0] offset;
		logic [BYTE_OFF_W-1:0]      byte_off;
	} addr_fields_t;

	// one load or store from the cpu
	typedef struct packed {
		addr_fields_t             addr;
		logic                     we;
		logic [`CACHE_BYTES-1:0]  be;
		word_t                    wdata;
	} cpu_req_t;

	typedef struct packed {
		logic  addr_ok;
		logic  data_ok;
		word_t rdata;
	} cpu_rsp_t;

	// lookup takes two cycles, wb and refill wait for the burst engine
	typedef enum logic [1:0] {
		CTRL_IDLE   = 2'b00,
		CTRL_LOOKUP = 2'b01,
		CTRL_WB     = 2'b10,
		CTRL_REFILL = 2'b11
	} ctrl_state_t;

endpackage

/* verilog/cache_settings.svh */
// geometry and bus width macros for the data cache, included by both packages and the RTL
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address split is tag 31:14, index 13:6, word 5:2, byte 1:0
`define CACHE_ADDR_W 32

// 256 lines
`define CACHE_INDEX_W 8

// 16 words per line
`define CACHE_OFFSET_W 4

// what is left of the address above index and offset
`define CACHE_TAG_W 18

// cpu and memory bus data word
`define CACHE_WORD_W 32

// byte enables per word
`define CACHE_BYTES 4

// burst length of one write-back or refill
`define CACHE_LINE_WORDS 16

`endif
